//--- bench/doodleSceneTb.sv
// Directed testbench for the platform scene.
// Checks initial placement, plain scrolling, wrap and respawn, scroll
// back-pressure and the pixel colour priority against a bench model of
// the platform field and its random X source.

`timescale 1ns/100ps

module doodleSceneTb;

    localparam int cycleLimit = 2000;
    localparam int halfPeriod = 50;

    logic                     frame_clk;
    logic                     loadplat;
    logic                     scrollValid;
    platformPkg::scrollDeltaT scrollDelta;
    logic                     scrollReady;
    videoPkg::coordT          drawX;
    videoPkg::coordT          drawY;
    videoPkg::coordT          doodleX;
    videoPkg::coordT          doodleY;
    videoPkg::coordT          doodleSize;
    videoPkg::coordT          cannonX;
    videoPkg::coordT          cannonY;
    videoPkg::coordT          cannonSize;
    videoPkg::colorT          red;
    videoPkg::colorT          green;
    videoPkg::colorT          blue;
    videoPkg::coordT          platX [platformPkg::platCount];
    videoPkg::coordT          platY [platformPkg::platCount];

    int          errorCount;
    int          checkCount;
    int          cycleCount;
    int          modelX [8];
    int          modelY [8];
    logic [8:0]  modelRng;

    doodleScene DUT
    (
        .frame_clk   (frame_clk),
        .loadplat    (loadplat),
        .scrollValid (scrollValid),
        .scrollDelta (scrollDelta),
        .scrollReady (scrollReady),
        .drawX       (drawX),
        .drawY       (drawY),
        .doodleX     (doodleX),
        .doodleY     (doodleY),
        .doodleSize  (doodleSize),
        .cannonX     (cannonX),
        .cannonY     (cannonY),
        .cannonSize  (cannonSize),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .platX       (platX),
        .platY       (platY)
    );

    initial
    begin
        frame_clk = 1'b0;
        forever
        begin
            #halfPeriod frame_clk = ~frame_clk;
        end
    end

    // hang guard
    initial
    begin
        cycleCount = 0;
        while (cycleCount < cycleLimit)
        begin
            @(posedge frame_clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("FAIL: see errors above");
        $finish;
    end

    // --------------------
    // reference model
    // --------------------
    // takes the current LFSR value, steps it and maps it onto the X range
    function automatic int takeX();
        int raw;
        raw = int'(modelRng);
        modelRng = {modelRng[7:0], modelRng[8] ^ modelRng[4]};
        if (raw <= 500)
        begin
            return raw + 20;
        end
        return raw - 200;
    endfunction

    task automatic modelScroll(input int delta);
        int sum;
        for (int i = 0; i < 8; i++)
        begin
            sum = modelY[i] + delta;
            if (sum > 479)
            begin
                modelY[i] = sum - 480;
                modelX[i] = takeX();
            end
            else
            begin
                modelY[i] = sum;
            end
        end
    endtask

    // --------------------
    // checks and handshake helpers
    // --------------------
    task automatic checkValue(input string testName, input int expected, input int actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("mismatch %s: expected 0x%0h actual 0x%0h", testName, expected, actual);
        end
    endtask

    task automatic checkField(input string testName);
        for (int i = 0; i < 8; i++)
        begin
            checkValue({testName, " x"}, modelX[i], int'(platX[i]));
            checkValue({testName, " y"}, modelY[i], int'(platY[i]));
        end
    endtask

    task automatic waitReady();
        @(negedge frame_clk);
        while (scrollReady !== 1'b1)
        begin
            @(negedge frame_clk);
        end
    endtask

    // holds the request until ready is seen, then drops valid after the transfer
    task automatic requestScroll(input int delta);
        scrollValid = 1'b1;
        scrollDelta = platformPkg::scrollDeltaT'(delta);
        while (scrollReady !== 1'b1)
        begin
            @(negedge frame_clk);
        end
        @(negedge frame_clk);
        scrollValid = 1'b0;
    endtask

    task automatic presentPixel(input int px, input int py, input int dx, input int dy,
                                input int ds, input int cx, input int cy, input int cs);
        drawX      = videoPkg::coordT'(px);
        drawY      = videoPkg::coordT'(py);
        doodleX    = videoPkg::coordT'(dx);
        doodleY    = videoPkg::coordT'(dy);
        doodleSize = videoPkg::coordT'(ds);
        cannonX    = videoPkg::coordT'(cx);
        cannonY    = videoPkg::coordT'(cy);
        cannonSize = videoPkg::coordT'(cs);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic resetAndPlace();
        for (int c = 0; c < 4; c++)
        begin
            @(negedge frame_clk);
            checkValue("reset ready", 0, int'(scrollReady));
            checkValue("reset rgb", 0, int'({red, green, blue}));
        end
        loadplat = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            modelX[i] = takeX();
            modelY[i] = 30 + 60 * i;
        end
        waitReady();
        checkField("placement");
    endtask

    task automatic plainScroll();
        requestScroll(10);
        waitReady();
        modelScroll(10);
        checkField("plain scroll");
    endtask

    task automatic wrapRespawn();
        int delta;
        for (int pass = 0; pass < 6; pass++)
        begin
            delta = int'($urandom_range(120, 60));
            requestScroll(delta);
            waitReady();
            modelScroll(delta);
            checkField("wrap respawn");
        end
    endtask

    task automatic backPressure();
        int firstDelta;
        int secondDelta;
        firstDelta  = int'($urandom_range(50, 20));
        secondDelta = int'($urandom_range(50, 20));
        requestScroll(firstDelta);
        checkValue("back-pressure ready", 0, int'(scrollReady));
        // second request waits through the first pass
        requestScroll(secondDelta);
        waitReady();
        modelScroll(firstDelta);
        modelScroll(secondDelta);
        checkField("back-pressure");
        for (int c = 0; c < 12; c++)
        begin
            @(negedge frame_clk);
            checkValue("back-pressure idle", 1, int'(scrollReady));
        end
        checkField("back-pressure repeat");
    endtask

    // one coordinate per cycle, each result checked a cycle later
    task automatic pixelColours();
        @(negedge frame_clk);
        presentPixel(modelX[2], modelY[2], 900, 900, 2, 900, 800, 2);
        @(negedge frame_clk);
        checkValue("pixel platform", 32'h66DD11, int'({red, green, blue}));
        presentPixel(modelX[1], modelY[1], modelX[1], modelY[1], 8, 900, 800, 2);
        @(negedge frame_clk);
        checkValue("pixel doodle", 32'hCAC92E, int'({red, green, blue}));
        presentPixel(650, 100, 900, 900, 2, 650, 100, 5);
        @(negedge frame_clk);
        checkValue("pixel cannon", 32'hFF0000, int'({red, green, blue}));
        presentPixel(700, 700, 900, 900, 2, 900, 800, 2);
        @(negedge frame_clk);
        checkValue("pixel background", 32'h988558, int'({red, green, blue}));
    endtask

    initial
    begin
        loadplat    = 1'b1;
        scrollValid = 1'b0;
        scrollDelta = '0;
        presentPixel(700, 700, 900, 900, 2, 900, 800, 2);
        errorCount = 0;
        checkCount = 0;
        modelRng   = 9'h1AB;
        void'($urandom(32'h1856));

        resetAndPlace();
        plainScroll();
        wrapRespawn();
        backPressure();
        pixelColours();

        $display("checks: %0d errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/videoPkg.sv
hw/platformPkg.sv
hw/platformRng.sv
hw/platformCtrl.sv
hw/platformStore.sv
hw/platformHit.sv
hw/pixelColor.sv
hw/doodleScene.sv
bench/doodleSceneTb.sv

//--- hw/doodleScene.sv
// Top level of the platform scene.
// Connects the sequencer, position store and random source of the platform
// field to the hit test and pixel colour path. Scroll requests use a
// valid/ready handshake; pixels stream in one per cycle with no handshake.

`timescale 1ns/100ps

module doodleScene
(
    input  logic                     frame_clk,
    input  logic                     loadplat,
    input  logic                     scrollValid,
    input  platformPkg::scrollDeltaT scrollDelta,
    output logic                     scrollReady,
    input  videoPkg::coordT          drawX,
    input  videoPkg::coordT          drawY,
    input  videoPkg::coordT          doodleX,
    input  videoPkg::coordT          doodleY,
    input  videoPkg::coordT          doodleSize,
    input  videoPkg::coordT          cannonX,
    input  videoPkg::coordT          cannonY,
    input  videoPkg::coordT          cannonSize,
    output videoPkg::colorT          red,
    output videoPkg::colorT          green,
    output videoPkg::colorT          blue,
    output videoPkg::coordT          platX [platformPkg::platCount],
    output videoPkg::coordT          platY [platformPkg::platCount]
);

    logic                     writeEn;
    platformPkg::platIndexT   writeIndex;
    logic                     initMode;
    platformPkg::scrollDeltaT stepDelta;
    platformPkg::rngT         rngValue;
    logic                     rngTake;
    logic                     platformOn;

    // --------------------
    // platform field
    // --------------------
    platformCtrl ctrl
    (
        .frame_clk   (frame_clk),
        .loadplat    (loadplat),
        .scrollValid (scrollValid),
        .scrollDelta (scrollDelta),
        .scrollReady (scrollReady),
        .writeEn     (writeEn),
        .writeIndex  (writeIndex),
        .initMode    (initMode),
        .stepDelta   (stepDelta)
    );

    platformStore store
    (
        .frame_clk  (frame_clk),
        .loadplat   (loadplat),
        .writeEn    (writeEn),
        .writeIndex (writeIndex),
        .initMode   (initMode),
        .stepDelta  (stepDelta),
        .rngValue   (rngValue),
        .rngTake    (rngTake),
        .platX      (platX),
        .platY      (platY)
    );

    platformRng rng
    (
        .frame_clk (frame_clk),
        .loadplat  (loadplat),
        .rngTake   (rngTake),
        .rngValue  (rngValue)
    );

    // --------------------
    // pixel path
    // --------------------
    platformHit hit
    (
        .drawX      (drawX),
        .drawY      (drawY),
        .platX      (platX),
        .platY      (platY),
        .platformOn (platformOn)
    );

    pixelColor color
    (
        .frame_clk  (frame_clk),
        .loadplat   (loadplat),
        .drawX      (drawX),
        .drawY      (drawY),
        .doodleX    (doodleX),
        .doodleY    (doodleY),
        .doodleSize (doodleSize),
        .cannonX    (cannonX),
        .cannonY    (cannonY),
        .cannonSize (cannonSize),
        .platformOn (platformOn),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

endmodule

//--- hw/pixelColor.sv
// Pixel colour stage.
// Tests the draw coordinate against the doodle and cannon squares, picks a
// colour with priority doodle, platform, cannon, background and registers
// it, giving one cycle of latency with a new pixel accepted every cycle.

`timescale 1ns/100ps

module pixelColor
(
    input  logic            frame_clk,
    input  logic            loadplat,
    input  videoPkg::coordT drawX,
    input  videoPkg::coordT drawY,
    input  videoPkg::coordT doodleX,
    input  videoPkg::coordT doodleY,
    input  videoPkg::coordT doodleSize,
    input  videoPkg::coordT cannonX,
    input  videoPkg::coordT cannonY,
    input  videoPkg::coordT cannonSize,
    input  logic            platformOn,
    output videoPkg::colorT red,
    output videoPkg::colorT green,
    output videoPkg::colorT blue
);

    logic doodleOn;
    logic cannonOn;

    // square of half size s around (cx, cy), compared without underflow
    function automatic logic squareHit(videoPkg::coordT px, videoPkg::coordT py,
                                       videoPkg::coordT cx, videoPkg::coordT cy,
                                       videoPkg::coordT s);
        return (11'(px) + 11'(s) >= 11'(cx)) && (11'(px) <= 11'(cx) + 11'(s)) &&
               (11'(py) + 11'(s) >= 11'(cy)) && (11'(py) <= 11'(cy) + 11'(s));
    endfunction

    assign doodleOn = squareHit(drawX, drawY, doodleX, doodleY, doodleSize);
    assign cannonOn = squareHit(drawX, drawY, cannonX, cannonY, cannonSize);

    // --------------------
    // priority select and output register
    // --------------------
    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else if (doodleOn)
        begin
            red   <= videoPkg::doodleRed;
            green <= videoPkg::doodleGreen;
            blue  <= videoPkg::doodleBlue;
        end
        else if (platformOn)
        begin
            red   <= videoPkg::platRed;
            green <= videoPkg::platGreen;
            blue  <= videoPkg::platBlue;
        end
        else if (cannonOn)
        begin
            red   <= videoPkg::cannonRed;
            green <= videoPkg::cannonGreen;
            blue  <= videoPkg::cannonBlue;
        end
        else
        begin
            red   <= videoPkg::backRed;
            green <= videoPkg::backGreen;
            blue  <= videoPkg::backBlue;
        end
    end

endmodule

//--- hw/platformCtrl.sv
// Sequencer for the platform field.
// After reset it sweeps every platform index once for initial placement,
// then waits for scroll requests on a valid/ready handshake and runs one
// sweep per accepted request. The store does the per-platform arithmetic.

`timescale 1ns/100ps

module platformCtrl
(
    input  logic                     frame_clk,
    input  logic                     loadplat,
    input  logic                     scrollValid,
    input  platformPkg::scrollDeltaT scrollDelta,
    output logic                     scrollReady,
    output logic                     writeEn,
    output platformPkg::platIndexT   writeIndex,
    output logic                     initMode,
    output platformPkg::scrollDeltaT stepDelta
);

    typedef enum logic [1:0]
    {
        place,
        idle,
        scroll
    } ctrlStateT;

    ctrlStateT             state;
    platformPkg::platIndexT index;
    logic                  lastWrite;
    logic                  transfer;

    assign lastWrite = (index == platformPkg::platIndexT'(platformPkg::platCount - 1));
    assign transfer  = scrollValid && scrollReady;

    // --------------------
    // state and index counter
    // --------------------
    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            state <= place;
            index <= '0;
        end
        else
        begin
            case (state)
                place, scroll:
                begin
                    index <= index + 1'b1;
                    if (lastWrite)
                    begin
                        state <= idle;
                    end
                end
                idle:
                begin
                    index <= '0;
                    if (transfer)
                    begin
                        state <= scroll;
                    end
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    // delta is held for the whole sweep
    always_ff @(posedge frame_clk)
    begin
        if (transfer)
        begin
            stepDelta <= scrollDelta;
        end
    end

    // --------------------
    // outputs decoded from state
    // --------------------
    assign scrollReady = (state == idle);
    assign writeEn     = (state != idle);
    assign initMode    = (state == place);
    assign writeIndex  = index;

endmodule

//--- hw/platformHit.sv
// Platform hit test for the current draw coordinate.
// Each platform is a rectangle of platHalfW by platHalfH around its centre;
// the result is high when the coordinate lies inside any of them.

`timescale 1ns/100ps

module platformHit
(
    input  videoPkg::coordT drawX,
    input  videoPkg::coordT drawY,
    input  videoPkg::coordT platX [platformPkg::platCount],
    input  videoPkg::coordT platY [platformPkg::platCount],
    output logic            platformOn
);

    logic [10:0] drawXWide;
    logic [10:0] drawYWide;

    assign drawXWide = 11'(drawX);
    assign drawYWide = 11'(drawY);

    // sizes are added on the opposite side instead of subtracted,
    // so platforms touching column or row zero are still drawn
    always_comb
    begin
        platformOn = 1'b0;
        for (int i = 0; i < platformPkg::platCount; i++)
        begin
            if ((drawXWide + 11'(platformPkg::platHalfW) >= 11'(platX[i])) &&
                (drawXWide <= 11'(platX[i]) + 11'(platformPkg::platHalfW)) &&
                (drawYWide + 11'(platformPkg::platHalfH) >= 11'(platY[i])) &&
                (drawYWide <= 11'(platY[i]) + 11'(platformPkg::platHalfH)))
            begin
                platformOn = 1'b1;
            end
        end
    end

endmodule

//--- hw/platformPkg.sv
// Platform field definitions: count, index and delta types, sizes,
// initial spacing and the random X generator constants.
// Modules refer to these names as platformPkg::name.

package platformPkg;

    // --------------------
    // field size and types
    // --------------------
    localparam int platCount = 8;

    typedef logic [2:0] platIndexT;
    typedef logic [7:0] scrollDeltaT;
    typedef logic [8:0] rngT;

    // --------------------
    // random generator
    // --------------------
    localparam rngT rngSeed    = 9'h1AB;
    localparam int  rngTapHigh = 8;
    localparam int  rngTapLow  = 4;

    // raw values up to the limit are shifted right by the margin,
    // larger ones are folded back so X stays on screen
    localparam rngT           platXLimit  = 9'd500;
    localparam videoPkg::coordT platXMargin = 10'd20;
    localparam videoPkg::coordT platXFold   = 10'd200;

    // --------------------
    // placement and size
    // --------------------
    // platform i starts at platYFirst + i * platYPitch
    localparam videoPkg::coordT platYFirst = 10'd30;
    localparam videoPkg::coordT platYPitch = 10'd60;

    localparam videoPkg::coordT platHalfW  = 10'd10;
    localparam videoPkg::coordT platHalfH  = 10'd4;

endpackage

//--- hw/platformRng.sv
// Shared pseudo-random source for platform X positions.
// A 9-bit Fibonacci LFSR that only advances when the store takes a value,
// so the X sequence depends on the order of use and not on elapsed time.

`timescale 1ns/100ps

module platformRng
(
    input  logic             frame_clk,
    input  logic             loadplat,
    input  logic             rngTake,
    output platformPkg::rngT rngValue
);

    logic feedback;

    // new bit shifted in at the bottom
    assign feedback = rngValue[platformPkg::rngTapHigh] ^ rngValue[platformPkg::rngTapLow];

    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            rngValue <= platformPkg::rngSeed;
        end
        else if (rngTake)
        begin
            // current value was consumed this cycle, move to the next one
            rngValue <= {rngValue[7:0], feedback};
        end
    end

endmodule

//--- hw/platformStore.sv
// Position registers for all platforms.
// One platform is updated per write: initial placement takes a fresh X and
// the fixed starting row, a scroll step moves the platform down and, when
// it falls past the bottom row, respawns it at the top with a new X.
// rngTake flags every cycle in which the generator value is used.

`timescale 1ns/100ps

module platformStore
(
    input  logic                     frame_clk,
    input  logic                     loadplat,
    input  logic                     writeEn,
    input  platformPkg::platIndexT   writeIndex,
    input  logic                     initMode,
    input  platformPkg::scrollDeltaT stepDelta,
    input  platformPkg::rngT         rngValue,
    output logic                     rngTake,
    output videoPkg::coordT          platX [platformPkg::platCount],
    output videoPkg::coordT          platY [platformPkg::platCount]
);

    logic [10:0]     stepSum;
    logic            wrap;
    videoPkg::coordT mappedX;
    videoPkg::coordT initY;
    videoPkg::coordT nextX;
    videoPkg::coordT nextY;

    // --------------------
    // update arithmetic
    // --------------------
    always_comb
    begin
        // map the raw value into the visible X range
        if (rngValue <= platformPkg::platXLimit)
        begin
            mappedX = videoPkg::coordT'(rngValue) + platformPkg::platXMargin;
        end
        else
        begin
            mappedX = videoPkg::coordT'(rngValue) - platformPkg::platXFold;
        end

        initY = platformPkg::platYFirst
              + videoPkg::coordT'(writeIndex) * platformPkg::platYPitch;

        // one extra bit so the sum never wraps before the bottom test
        stepSum = 11'(platY[writeIndex]) + 11'(stepDelta);
        wrap    = (stepSum > 11'(videoPkg::screenYMax));

        if (initMode)
        begin
            nextX = mappedX;
            nextY = initY;
        end
        else if (wrap)
        begin
            nextX = mappedX;
            nextY = videoPkg::coordT'(stepSum - 11'(videoPkg::screenHeight));
        end
        else
        begin
            nextX = platX[writeIndex];
            nextY = videoPkg::coordT'(stepSum);
        end
    end

    assign rngTake = writeEn && (initMode || wrap);

    // --------------------
    // position registers
    // --------------------
    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            for (int i = 0; i < platformPkg::platCount; i++)
            begin
                platX[i] <= '0;
                platY[i] <= '0;
            end
        end
        else if (writeEn)
        begin
            platX[writeIndex] <= nextX;
            platY[writeIndex] <= nextY;
        end
    end

endmodule

//--- hw/videoPkg.sv
// Screen geometry and colour definitions for the scene.
// Shared by the platform store, the hit tests and the pixel colour stage.
// Modules refer to these names as videoPkg::name.

package videoPkg;

    // --------------------
    // coordinate and channel types
    // --------------------
    typedef logic [9:0] coordT;
    typedef logic [7:0] colorT;

    // bottom visible row, and the distance a wrapped platform moves back up
    localparam coordT screenYMax   = 10'd479;
    localparam coordT screenHeight = 10'd480;

    // --------------------
    // colour table
    // --------------------
    localparam colorT doodleRed   = 8'hCA;
    localparam colorT doodleGreen = 8'hC9;
    localparam colorT doodleBlue  = 8'h2E;

    localparam colorT platRed     = 8'h66;
    localparam colorT platGreen   = 8'hDD;
    localparam colorT platBlue    = 8'h11;

    localparam colorT cannonRed   = 8'hFF;
    localparam colorT cannonGreen = 8'h00;
    localparam colorT cannonBlue  = 8'h00;

    // sandy background
    localparam colorT backRed     = 8'h98;
    localparam colorT backGreen   = 8'h85;
    localparam colorT backBlue    = 8'h58;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the platform scene testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module doodleSceneTb -o doodleSceneSim

./obj_dir/doodleSceneSim > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported errors"
    exit 1
fi

echo "simulation finished without errors"
